//--- sim.f
+incdir+include
rtl/mm_monitor_pkg.sv
rtl/mm_wait_gen.sv
rtl/mm_command_fifo.sv
rtl/mm_api_port.sv
rtl/mm_monitor_top.sv
testbench/tb_mm_monitor.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_mm_monitor -o tb_mm_monitor &&
./obj_dir/tb_mm_monitor | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run.sh: ok" ||
{ echo "run.sh: failure"; exit 1; }

//--- testbench/tb_mm_monitor.sv
`include "mm_monitor_settings.svh"

module tb_mm_monitor;
   timeunit 1ns;
   timeprecision 100ps;

   import mm_monitor_pkg::*;

   localparam int READ_WAIT  = `MM_READ_WAIT;
   localparam int WRITE_WAIT = `MM_WRITE_WAIT;
   localparam int DEPTH      = `MM_FIFO_DEPTH;
   localparam int NUM_RANDOM = 6;
   // about 14 commands and 60 host calls need well under 400 cycles
   localparam int MAX_CYCLES = 2000;

   logic    req, reset;
   logic    avs_read, avs_write, avs_waitrequest, avs_readdatavalid;
   addr_t   avs_address, avm_address;
   byteen_t avs_byteenable, avm_byteenable;
   data_t   avs_writedata, avs_readdata, avm_writedata, avm_readdata;
   logic    avm_read, avm_write, avm_waitrequest, avm_readdatavalid;
   logic    cmd, ack;
   api_op_e cmd_op;
   word_t   cmd_data, data_out;
   logic    cmd_received, threshold_hit, overflow;

   logic [31:0] rng_state;
   logic        stall_enable;
   int          errors, checks, thr_pulses, cycle_count;

   mm_monitor_top u_mm_monitor_top (.*);

   initial begin
      req = 1'b0;
      forever #50 req = ~req;
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   // downstream slave, stalls about one cycle in four
   always @(posedge req) begin
      #1;
      if (stall_enable)
         avm_waitrequest = (lcg_next() < 32'h4000_0000);
      else
         avm_waitrequest = 1'b0;
   end

   always @(negedge req) begin
      if (!reset && threshold_hit)
         thr_pulses++;
   end

   task automatic tick();
      @(posedge req);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] t=%0d ns %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic api_call(input api_op_e op, input word_t value, output word_t result);
      tick();
      cmd      = 1'b1;
      cmd_op   = op;
      cmd_data = value;
      @(negedge req);
      check_value("ack", ack, 1'b0);
      tick();
      cmd      = 1'b0;
      cmd_data = '0;
      @(negedge req);
      check_value("ack", ack, 1'b1); // exactly one cycle after cmd
      result = data_out;
   endtask

   task automatic api_expect(input api_op_e op, input string name, input word_t exp);
      word_t result;
      api_call(op, '0, result);
      check_value(name, result, exp);
   endtask

   // presents one command and follows it cycle by cycle until it is taken
   task automatic issue_command(input logic is_write, input addr_t addr, input byteen_t be,
                                input data_t wdata, output int waited,
                                output logic rcv, output logic thr, output logic ovf);
      int    needed;
      int    k;
      logic  done;
      addr_t byte_addr;
      needed    = is_write ? WRITE_WAIT : READ_WAIT;
      byte_addr = `MM_WORD_ADDRESSING ? (addr << 2) : addr;
      waited    = 0;
      k         = 0;
      done      = 1'b0;
      tick();
      avs_read       = !is_write;
      avs_write      = is_write;
      avs_address    = addr;
      avs_byteenable = be;
      avs_writedata  = wdata;
      while (!done && k < 40) begin
         @(negedge req);
         if (k < needed) begin
            check_value("avs_waitrequest", avs_waitrequest, 1'b1);
            check_value("avm_read", avm_read, 1'b0);
            check_value("avm_write", avm_write, 1'b0);
         end else begin
            check_value("avs_waitrequest", avs_waitrequest, avm_waitrequest);
            check_value("avm_read", avm_read, !is_write);
            check_value("avm_write", avm_write, is_write);
         end
         done = !avs_waitrequest; // DUT takes the command
         check_value("avm_address", avm_address, byte_addr);
         check_value("avm_byteenable", avm_byteenable, be);
         check_value("avm_writedata", avm_writedata, wdata);
         if (avs_waitrequest)
            waited++;
         k++;
         if (!done)
            tick();
      end
      assert (done) else begin
         errors++;
         $display("command at word address %0h was never accepted", addr);
      end
      tick();
      avs_read  = 1'b0;
      avs_write = 1'b0;
      @(negedge req);
      rcv = cmd_received;
      thr = threshold_hit;
      ovf = overflow;
   endtask

   task automatic test_read_passthrough();
      int    waited;
      logic  rcv, thr, ovf;
      word_t r;
      tick();
      avm_readdata      = 32'hcafe_f00d;
      avm_readdatavalid = 1'b1;
      issue_command(1'b0, 32'd5, 4'b1010, 32'h1234_5678, waited, rcv, thr, ovf);
      check_value("wait cycles", waited, READ_WAIT);
      check_value("avm_address", avm_address, 32'd20);
      check_value("avs_readdata", avs_readdata, 32'hcafe_f00d);
      check_value("avs_readdatavalid", avs_readdatavalid, 1'b1);
      check_value("cmd_received", rcv, 1'b1);
      avm_readdatavalid = 1'b0;
      api_expect(GET_COMMAND_ADDRESS, "head address", 32'd20);
      api_call(POP_COMMAND, '0, r);
   endtask

   task automatic test_random_stall();
      logic    kind_q [NUM_RANDOM];
      addr_t   addr_q [NUM_RANDOM];
      byteen_t be_q   [NUM_RANDOM];
      data_t   data_q [NUM_RANDOM];
      int      waited;
      logic    rcv, thr, ovf;
      word_t   r;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         r         = lcg_next();
         kind_q[i] = r[16];
         be_q[i]   = r[23:20];
         addr_q[i] = lcg_next();
         data_q[i] = kind_q[i] ? lcg_next() : '0; // reads carry no data
      end
      stall_enable = 1'b1;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         issue_command(kind_q[i], addr_q[i], be_q[i], data_q[i], waited, rcv, thr, ovf);
         check_value("cmd_received", rcv, 1'b1);
         check_value("overflow", ovf, 1'b0);
      end
      stall_enable = 1'b0;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         api_expect(GET_COMMAND_REQUEST, "head kind", kind_q[i] ? 32'd2 : 32'd1);
         api_expect(GET_COMMAND_ADDRESS, "head address", addr_q[i] << 2);
         api_expect(GET_COMMAND_DATA, "head data", data_q[i]);
         api_expect(GET_COMMAND_BYTE_ENABLE, "head byte enable", be_q[i]);
         api_call(POP_COMMAND, '0, r);
         api_expect(GET_QUEUE_SIZE, "queue size", NUM_RANDOM - 1 - i);
      end
      api_expect(GET_COMMAND_REQUEST, "empty head kind", 32'd0);
   endtask

   task automatic test_fifo_max();
      int    waited;
      logic  rcv, thr, ovf;
      word_t r;
      api_call(SET_FIFO_MAX, 32'd3, r);
      api_expect(GET_FIFO_MAX, "fifo max", 32'd3);
      for (int i = 0; i < 4; i++) begin
         issue_command(1'b1, 32'h100 + i, 4'hf, 32'hd00d_0000 + i, waited, rcv, thr, ovf);
         check_value("cmd_received", rcv, 1'b1);
         check_value("overflow", ovf, i == 3); // fourth finds the queue full
      end
      api_expect(GET_QUEUE_SIZE, "queue size", 32'd3);
      api_call(SET_FIFO_MAX, 32'd0, r);
      api_expect(GET_FIFO_MAX, "fifo max", DEPTH);
   endtask

   task automatic test_threshold();
      int    waited;
      int    pulses_before;
      logic  rcv, thr, ovf;
      word_t r;
      for (int i = 0; i < 3; i++)
         api_call(POP_COMMAND, '0, r);
      api_expect(GET_QUEUE_SIZE, "queue size", 32'd0);
      api_call(SET_FIFO_THRESHOLD, 32'd2, r);
      pulses_before = thr_pulses;
      for (int i = 0; i < 3; i++) begin
         issue_command(1'b0, 32'h40 + i, 4'h3, '0, waited, rcv, thr, ovf);
         check_value("cmd_received", rcv, 1'b1);
         check_value("threshold_hit", thr, i == 1);
      end
      check_value("threshold_hit pulses", thr_pulses - pulses_before, 32'd1);
   endtask

   task automatic test_init();
      word_t r;
      api_expect(GET_FIFO_THRESHOLD, "fifo threshold", 32'd2);
      api_expect(GET_QUEUE_SIZE, "queue size", 32'd3);
      api_call(INIT, '0, r);
      check_value("init data_out", r, 32'd0);
      api_expect(GET_QUEUE_SIZE, "queue size", 32'd0);
      api_expect(GET_FIFO_MAX, "fifo max", DEPTH);
      api_expect(GET_FIFO_THRESHOLD, "fifo threshold", 32'd0);
      api_expect(GET_COMMAND_REQUEST, "empty head kind", 32'd0);
   endtask

   initial begin
      rng_state         = 32'hb007;
      errors            = 0;
      checks            = 0;
      thr_pulses        = 0;
      stall_enable      = 1'b0;
      reset             = 1'b1;
      avs_read          = 1'b0;
      avs_write         = 1'b0;
      avs_address       = '0;
      avs_byteenable    = '0;
      avs_writedata     = '0;
      avm_waitrequest   = 1'b0;
      avm_readdata      = '0;
      avm_readdatavalid = 1'b0;
      cmd               = 1'b0;
      cmd_op            = GET_FIFO_MAX;
      cmd_data          = '0;
      repeat (5) @(posedge req);
      #1 reset = 1'b0;
      @(negedge req);
      check_value("ack", ack, 1'b0);
      check_value("events", {cmd_received, threshold_hit, overflow}, 3'b000);
      check_value("avs_waitrequest", avs_waitrequest, 1'b0);
      api_expect(GET_FIFO_MAX, "reset fifo max", DEPTH);
      api_expect(GET_FIFO_THRESHOLD, "reset fifo threshold", 32'd0);
      api_expect(GET_QUEUE_SIZE, "reset queue size", 32'd0);
      test_read_passthrough();
      test_random_stall();
      test_fifo_max();
      test_threshold();
      test_init();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge req);
         cycle_count++;
      end
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- rtl/mm_monitor_top.sv
module mm_monitor_top (
   input  logic                    req,
   input  logic                    reset,
   input  logic                    avs_read,
   input  logic                    avs_write,
   input  mm_monitor_pkg::addr_t   avs_address,
   input  mm_monitor_pkg::byteen_t avs_byteenable,
   input  mm_monitor_pkg::data_t   avs_writedata,
   output logic                    avs_waitrequest,
   output mm_monitor_pkg::data_t   avs_readdata,
   output logic                    avs_readdatavalid,
   output logic                    avm_read,
   output logic                    avm_write,
   output mm_monitor_pkg::addr_t   avm_address,
   output mm_monitor_pkg::byteen_t avm_byteenable,
   output mm_monitor_pkg::data_t   avm_writedata,
   input  logic                    avm_waitrequest,
   input  mm_monitor_pkg::data_t   avm_readdata,
   input  logic                    avm_readdatavalid,
   input  logic                    cmd,
   input  mm_monitor_pkg::api_op_e cmd_op,
   input  mm_monitor_pkg::word_t   cmd_data,
   output logic                    ack,
   output mm_monitor_pkg::word_t   data_out,
   output logic                    cmd_received,
   output logic                    threshold_hit,
   output logic                    overflow
);
   import mm_monitor_pkg::*;

   logic      accept;
   logic      cmd_is_write;
   addr_t     cmd_address;
   byteen_t   cmd_byteenable;
   data_t     cmd_writedata;
   logic      set_max;
   logic      set_threshold;
   logic      pop;
   logic      flush;
   count_t    set_value;
   cmd_kind_e head_kind;
   addr_t     head_address;
   byteen_t   head_byteenable;
   data_t     head_writedata;
   count_t    fill;
   count_t    fifo_max;
   count_t    fifo_threshold;

   // read responses are not captured
   assign avs_readdata      = avm_readdata;
   assign avs_readdatavalid = avm_readdatavalid;

   mm_wait_gen u_wait_gen (
      .req             (req),
      .reset           (reset),
      .avs_read        (avs_read),
      .avs_write       (avs_write),
      .avs_address     (avs_address),
      .avs_byteenable  (avs_byteenable),
      .avs_writedata   (avs_writedata),
      .avm_waitrequest (avm_waitrequest),
      .avs_waitrequest (avs_waitrequest),
      .avm_read        (avm_read),
      .avm_write       (avm_write),
      .avm_address     (avm_address),
      .avm_byteenable  (avm_byteenable),
      .avm_writedata   (avm_writedata),
      .accept          (accept),
      .cmd_is_write    (cmd_is_write),
      .cmd_address     (cmd_address),
      .cmd_byteenable  (cmd_byteenable),
      .cmd_writedata   (cmd_writedata)
   );

   mm_command_fifo u_command_fifo (
      .req             (req),
      .reset           (reset),
      .accept          (accept),
      .cmd_is_write    (cmd_is_write),
      .cmd_address     (cmd_address),
      .cmd_byteenable  (cmd_byteenable),
      .cmd_writedata   (cmd_writedata),
      .set_max         (set_max),
      .set_threshold   (set_threshold),
      .pop             (pop),
      .flush           (flush),
      .set_value       (set_value),
      .head_kind       (head_kind),
      .head_address    (head_address),
      .head_byteenable (head_byteenable),
      .head_writedata  (head_writedata),
      .fill            (fill),
      .fifo_max        (fifo_max),
      .fifo_threshold  (fifo_threshold),
      .cmd_received    (cmd_received),
      .threshold_hit   (threshold_hit),
      .overflow        (overflow)
   );

   mm_api_port u_api_port (
      .req             (req),
      .reset           (reset),
      .cmd             (cmd),
      .cmd_op          (cmd_op),
      .cmd_data        (cmd_data),
      .head_kind       (head_kind),
      .head_address    (head_address),
      .head_byteenable (head_byteenable),
      .head_writedata  (head_writedata),
      .fill            (fill),
      .fifo_max        (fifo_max),
      .fifo_threshold  (fifo_threshold),
      .set_max         (set_max),
      .set_threshold   (set_threshold),
      .pop             (pop),
      .flush           (flush),
      .set_value       (set_value),
      .ack             (ack),
      .data_out        (data_out)
   );

endmodule

//--- rtl/mm_api_port.sv
module mm_api_port (
   input  logic                      req,
   input  logic                      reset,
   input  logic                      cmd,
   input  mm_monitor_pkg::api_op_e   cmd_op,
   input  mm_monitor_pkg::word_t     cmd_data,
   input  mm_monitor_pkg::cmd_kind_e head_kind,
   input  mm_monitor_pkg::addr_t     head_address,
   input  mm_monitor_pkg::byteen_t   head_byteenable,
   input  mm_monitor_pkg::data_t     head_writedata,
   input  mm_monitor_pkg::count_t    fill,
   input  mm_monitor_pkg::count_t    fifo_max,
   input  mm_monitor_pkg::count_t    fifo_threshold,
   output logic                      set_max,
   output logic                      set_threshold,
   output logic                      pop,
   output logic                      flush,
   output mm_monitor_pkg::count_t    set_value,
   output logic                      ack,
   output mm_monitor_pkg::word_t     data_out
);
   import mm_monitor_pkg::*;

   localparam int COUNT_W = $bits(count_t);

   word_t read_value;

   // strobes act on the same edge that raises ack
   assign set_max       = cmd && (cmd_op == SET_FIFO_MAX);
   assign set_threshold = cmd && (cmd_op == SET_FIFO_THRESHOLD);
   assign pop           = cmd && (cmd_op == POP_COMMAND);
   assign flush         = cmd && (cmd_op == INIT);

   // saturate large host values instead of wrapping
   assign set_value = (|cmd_data[$bits(word_t)-1:COUNT_W]) ? '1 : cmd_data[COUNT_W-1:0];

   always_comb begin
      read_value = '0;
      case (cmd_op)
         GET_FIFO_MAX:            read_value = word_t'(fifo_max);
         GET_FIFO_THRESHOLD:      read_value = word_t'(fifo_threshold);
         GET_QUEUE_SIZE:          read_value = word_t'(fill);
         GET_COMMAND_REQUEST:     read_value = word_t'(head_kind);
         GET_COMMAND_ADDRESS:     read_value = word_t'(head_address);
         GET_COMMAND_DATA:        read_value = word_t'(head_writedata);
         GET_COMMAND_BYTE_ENABLE: read_value = word_t'(head_byteenable);
         default:                 read_value = '0; // set, pop, init
      endcase
   end

   always_ff @(posedge req) begin
      if (reset)
         ack <= 1'b0;
      else
         ack <= cmd;
   end

   always_ff @(posedge req) begin
      if (cmd)
         data_out <= read_value; // held until next ack
   end

endmodule

//--- rtl/mm_command_fifo.sv
`include "mm_monitor_settings.svh"

module mm_command_fifo (
   input  logic                      req,
   input  logic                      reset,
   input  logic                      accept,
   input  logic                      cmd_is_write,
   input  mm_monitor_pkg::addr_t     cmd_address,
   input  mm_monitor_pkg::byteen_t   cmd_byteenable,
   input  mm_monitor_pkg::data_t     cmd_writedata,
   input  logic                      set_max,
   input  logic                      set_threshold,
   input  logic                      pop,
   input  logic                      flush,
   input  mm_monitor_pkg::count_t    set_value,
   output mm_monitor_pkg::cmd_kind_e head_kind,
   output mm_monitor_pkg::addr_t     head_address,
   output mm_monitor_pkg::byteen_t   head_byteenable,
   output mm_monitor_pkg::data_t     head_writedata,
   output mm_monitor_pkg::count_t    fill,
   output mm_monitor_pkg::count_t    fifo_max,
   output mm_monitor_pkg::count_t    fifo_threshold,
   output logic                      cmd_received,
   output logic                      threshold_hit,
   output logic                      overflow
);
   import mm_monitor_pkg::*;

   localparam int     DEPTH       = `MM_FIFO_DEPTH;
   localparam int     PTR_W       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam count_t DEFAULT_MAX = count_t'(DEPTH);

   logic             mem_write      [DEPTH];
   addr_t            mem_address    [DEPTH];
   byteen_t          mem_byteenable [DEPTH];
   data_t            mem_writedata  [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             full;
   logic             push;
   logic             pop_ok;
   count_t           fill_next;
   count_t           max_req;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full   = (fill >= fifo_max); // programmable limit, not the physical depth
   assign push   = accept && !full && !flush;
   assign pop_ok = pop && (fill != '0) && !flush; // empty pop ignored

   // 0 or beyond the depth means full depth
   assign max_req = (set_value == '0 || set_value > DEFAULT_MAX) ? DEFAULT_MAX : set_value;

   always_comb begin
      fill_next = fill;
      if (flush)
         fill_next = '0;
      else if (push && !pop_ok)
         fill_next = fill + 1'b1;
      else if (pop_ok && !push)
         fill_next = fill - 1'b1;
   end

   always_ff @(posedge req) begin
      if (push) begin
         mem_write[wr_ptr]      <= cmd_is_write;
         mem_address[wr_ptr]    <= cmd_address;
         mem_byteenable[wr_ptr] <= cmd_byteenable;
         mem_writedata[wr_ptr]  <= cmd_writedata;
      end
   end

   always_ff @(posedge req) begin
      if (reset) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         fill           <= '0;
         fifo_max       <= DEFAULT_MAX;
         fifo_threshold <= '0;
         cmd_received   <= 1'b0;
         threshold_hit  <= 1'b0;
         overflow       <= 1'b0;
      end else begin
         cmd_received  <= accept;
         overflow      <= accept && full;
         threshold_hit <= push && (fifo_threshold != '0) && (fill_next == fifo_threshold);
         fill          <= fill_next;
         if (flush) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fifo_max       <= DEFAULT_MAX;
            fifo_threshold <= '0;
         end else begin
            if (push)
               wr_ptr <= next_ptr(wr_ptr);
            if (pop_ok)
               rd_ptr <= next_ptr(rd_ptr);
            // a new limit never drops below what is already queued
            if (set_max)
               fifo_max <= (max_req < fill_next) ? fill_next : max_req;
            if (set_threshold)
               fifo_threshold <= set_value;
         end
      end
   end

   assign head_kind       = (fill == '0) ? NONE : (mem_write[rd_ptr] ? WRITE : READ);
   assign head_address    = mem_address[rd_ptr];
   assign head_byteenable = mem_byteenable[rd_ptr];
   assign head_writedata  = mem_writedata[rd_ptr];

   a_fill_bounded: assert property (@(posedge req) disable iff (reset)
      fill <= fifo_max);

endmodule

//--- rtl/mm_wait_gen.sv
`include "mm_monitor_settings.svh"

module mm_wait_gen (
   input  logic                    req,
   input  logic                    reset,
   input  logic                    avs_read,
   input  logic                    avs_write,
   input  mm_monitor_pkg::addr_t   avs_address,
   input  mm_monitor_pkg::byteen_t avs_byteenable,
   input  mm_monitor_pkg::data_t   avs_writedata,
   input  logic                    avm_waitrequest,
   output logic                    avs_waitrequest,
   output logic                    avm_read,
   output logic                    avm_write,
   output mm_monitor_pkg::addr_t   avm_address,
   output mm_monitor_pkg::byteen_t avm_byteenable,
   output mm_monitor_pkg::data_t   avm_writedata,
   output logic                    accept,
   output logic                    cmd_is_write,
   output mm_monitor_pkg::addr_t   cmd_address,
   output mm_monitor_pkg::byteen_t cmd_byteenable,
   output mm_monitor_pkg::data_t   cmd_writedata
);
   localparam int READ_WAIT  = `MM_READ_WAIT;
   localparam int WRITE_WAIT = `MM_WRITE_WAIT;
   localparam int MAX_WAIT   = (READ_WAIT > WRITE_WAIT) ? READ_WAIT : WRITE_WAIT;
   localparam int WAIT_W     = (MAX_WAIT > 0) ? $clog2(MAX_WAIT + 1) : 1;
   localparam int ADDR_SHIFT = `MM_WORD_ADDRESSING ? $clog2(`MM_NUM_SYMBOLS) : 0;

   logic [WAIT_W-1:0] wait_cnt;
   logic [WAIT_W-1:0] wait_need;
   logic              active;
   logic              counting;
   logic              done;

   assign active    = avs_read || avs_write;
   assign wait_need = avs_write ? WAIT_W'(WRITE_WAIT) : WAIT_W'(READ_WAIT);
   assign counting  = active && (wait_cnt < wait_need);
   assign done      = active && !counting;

   // downstream only sees the command once the inserted waits are over
   assign avs_waitrequest = counting || (done && avm_waitrequest);
   assign avm_read        = avs_read && done;
   assign avm_write       = avs_write && done;
   assign accept          = done && !avm_waitrequest;

   assign avm_address    = avs_address << ADDR_SHIFT; // words to bytes
   assign avm_byteenable = avs_byteenable;
   assign avm_writedata  = avs_writedata;

   assign cmd_is_write   = avs_write;
   assign cmd_address    = avm_address;
   assign cmd_byteenable = avs_byteenable;
   assign cmd_writedata  = avs_writedata;

   always_ff @(posedge req) begin
      if (reset) begin
         wait_cnt <= '0;
      end else if (accept) begin
         wait_cnt <= '0;
      end else if (counting) begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   a_one_command: assert property (@(posedge req) disable iff (reset)
      !(avs_read && avs_write));

   // master must hold a stalled command until it is taken
   a_stall_stable: assert property (@(posedge req) disable iff (reset)
      (active && avs_waitrequest) |=>
         $stable(avs_read) && $stable(avs_write) && $stable(avs_address) &&
         $stable(avs_byteenable) && (!avs_write || $stable(avs_writedata)));

endmodule

//--- rtl/mm_monitor_pkg.sv
`include "mm_monitor_settings.svh"

package mm_monitor_pkg;

   typedef logic [`MM_ADDR_W-1:0] addr_t;
   typedef logic [`MM_SYMBOL_W*`MM_NUM_SYMBOLS-1:0] data_t;
   typedef logic [`MM_NUM_SYMBOLS-1:0] byteen_t;
   typedef logic [$clog2(`MM_FIFO_DEPTH+1)-1:0] count_t; // fill, max, threshold
   typedef logic [`MM_API_W-1:0] word_t;

   typedef enum logic [3:0] {
      SET_FIFO_MAX            = 4'd0,
      GET_FIFO_MAX            = 4'd1,
      SET_FIFO_THRESHOLD      = 4'd2,
      GET_FIFO_THRESHOLD      = 4'd3,
      POP_COMMAND             = 4'd4,
      GET_QUEUE_SIZE          = 4'd5,
      GET_COMMAND_REQUEST     = 4'd6,
      GET_COMMAND_ADDRESS     = 4'd7,
      GET_COMMAND_DATA        = 4'd8,
      GET_COMMAND_BYTE_ENABLE = 4'd9,
      INIT                    = 4'd10
   } api_op_e;

   typedef enum logic [1:0] {
      NONE  = 2'd0, // empty queue
      READ  = 2'd1,
      WRITE = 2'd2
   } cmd_kind_e;

endpackage

//--- include/mm_monitor_settings.svh
`ifndef MM_MONITOR_SETTINGS_SVH
`define MM_MONITOR_SETTINGS_SVH

// bus data shape
`define MM_SYMBOL_W 8
`define MM_NUM_SYMBOLS 4

// byte address width on the downstream side
`define MM_ADDR_W 32

// 1: upstream address counts words, shifted to bytes downstream
`define MM_WORD_ADDRESSING 1

// host API data width
`define MM_API_W 32

// physical capture depth
`define MM_FIFO_DEPTH 16

// inserted wait states per command
`define MM_READ_WAIT 2
`define MM_WRITE_WAIT 1

`endif
